//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_frame_buf
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- desc_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module desc_fifo
    import frame_buf_pkg::*;
#(
    parameter int DESC_DEPTH = 16
) (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_push,
    input  wire frame_desc_t   i_desc,
    input  wire                i_pop,
    output frame_desc_t        o_head,
    output logic               o_empty,
    output logic               o_full
);

    localparam int PTR_W = $clog2(DESC_DEPTH);
    localparam int CNT_W = $clog2(DESC_DEPTH + 1);

    frame_desc_t      mem [DESC_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow requests are dropped
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DESC_DEPTH));

    // fwft head
    assign o_head = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_desc;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DESC_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DESC_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // occupancy
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- flist.f
frame_buf_pkg.sv
frame_ram.sv
desc_fifo.sv
frame_writer.sv
frame_reader.sv
frame_buf_top.sv
frame_buf_chk.sv
tb_frame_buf.sv

//--- frame_buf_chk.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buf_chk #(
    parameter bit QUEUE_CHK  = 1'b1,
    parameter bit STREAM_CHK = 1'b1
) (
    input wire i_clk,
    input wire i_rst,
    input wire i_push,
    input wire i_full,
    input wire i_pop,
    input wire i_empty,
    input wire i_valid,
    input wire i_last
);

    //////////////////////////////////////////////////////////////////////
    // descriptor queue protocol
    //////////////////////////////////////////////////////////////////////

    if (QUEUE_CHK) begin : g_queue
        a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
            !(i_push && i_full))
            else $error("descriptor pushed while the queue is full");

        a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
            !(i_pop && i_empty))
            else $error("descriptor popped while the queue is empty");
    end

    //////////////////////////////////////////////////////////////////////
    // output framing
    //////////////////////////////////////////////////////////////////////

    if (STREAM_CHK) begin : g_stream
        // last is a qualifier of a valid byte
        a_last_with_valid: assert property (@(posedge i_clk) disable iff (i_rst)
            i_last |-> i_valid)
            else $error("o_last seen without o_valid");

        a_quiet_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_valid)
            else $error("o_valid high while reset is active");
    end

endmodule

// queue side checks push and pop against the flags
bind desc_fifo frame_buf_chk #(
    .QUEUE_CHK  (1'b1),
    .STREAM_CHK (1'b0)
) i_fifo_chk (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (i_push),
    .i_full  (o_full),
    .i_pop   (i_pop),
    .i_empty (o_empty),
    .i_valid (1'b0),
    .i_last  (1'b0)
);

// reader side checks the output stream framing
bind frame_reader frame_buf_chk #(
    .QUEUE_CHK  (1'b0),
    .STREAM_CHK (1'b1)
) i_reader_chk (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (1'b0),
    .i_full  (1'b0),
    .i_pop   (1'b0),
    .i_empty (1'b0),
    .i_valid (o_valid),
    .i_last  (o_last)
);

`default_nettype wire

//--- frame_buf_pkg.sv
`default_nettype none

package frame_buf_pkg;

    //////////////////////////////////////////////////////////////////////
    // smd codes
    //////////////////////////////////////////////////////////////////////

    // start of preemptable frame, also fragment count 0..3 on frag strobe
    localparam logic [7:0] SMD_S0 = 8'he6;
    localparam logic [7:0] SMD_S1 = 8'h4c;
    localparam logic [7:0] SMD_S2 = 8'h7f;
    localparam logic [7:0] SMD_S3 = 8'hb3;

    localparam int FRAG_CODE_W = 2;

    // address width for the default 2048 byte ram
    localparam int ADDR_W = 11;
    localparam int LEN_W  = 12;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////

    // one stored frame
    typedef struct packed {
        logic [7:0]             smd;
        logic [FRAG_CODE_W-1:0] frag;
        logic [1:0]             crc_flags;  // bit 0 crc ok, bit 1 mcrc ok
        addr_t                  start_addr;
        len_t                   length;
    } frame_desc_t;

    // user word on the output stream
    typedef struct packed {
        logic                   marker;
        logic [7:0]             smd;
        logic [FRAG_CODE_W-1:0] frag;
        logic [1:0]             crc_flags;
        logic [2:0]             rsvd;
    } axis_user_t;

    // incoming byte stream, last and crc bits valid with the final byte
    typedef struct packed {
        logic [7:0] data;
        logic       strb;
        logic       last;
        logic       crc_err;
        logic [1:0] crc_flags;
    } frame_in_t;

    // ring address step, wraps at the ram depth
    function automatic addr_t addr_next(input addr_t addr, input int depth);
        return (addr == addr_t'(depth - 1)) ? '0 : addr + addr_t'(1);
    endfunction

endpackage

`default_nettype wire

//--- frame_buf_top.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buf_top
    import frame_buf_pkg::*;
#(
    parameter int RAM_DEPTH  = 2048,
    parameter int DESC_DEPTH = 16
) (
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire frame_in_t   i_frame,
    input  wire [7:0]        i_smd,
    input  wire              i_smd_vld,
    input  wire [7:0]        i_frag,
    input  wire              i_frag_vld,
    output logic [7:0]       o_data,
    output logic             o_valid,
    output logic             o_last,
    output axis_user_t       o_user,
    output len_t             o_len
);

    // write side
    logic        wr_en;
    addr_t       wr_addr;
    logic [7:0]  wr_data;
    // descriptor queue
    logic        desc_push;
    frame_desc_t push_desc;
    logic        desc_full;
    frame_desc_t head_desc;
    logic        desc_empty;
    logic        desc_pop;
    // read side
    logic        rd_en;
    addr_t       rd_addr;
    logic [7:0]  rd_data;

    frame_writer #(
        .RAM_DEPTH (RAM_DEPTH)
    ) i_frame_writer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frame     (i_frame),
        .i_smd       (i_smd),
        .i_smd_vld   (i_smd_vld),
        .i_frag      (i_frag),
        .i_frag_vld  (i_frag_vld),
        .i_desc_full (desc_full),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_desc_push (desc_push),
        .o_desc      (push_desc)
    );

    frame_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) i_frame_ram (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    desc_fifo #(
        .DESC_DEPTH (DESC_DEPTH)
    ) i_desc_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (desc_push),
        .i_desc  (push_desc),
        .i_pop   (desc_pop),
        .o_head  (head_desc),
        .o_empty (desc_empty),
        .o_full  (desc_full)
    );

    frame_reader #(
        .RAM_DEPTH (RAM_DEPTH)
    ) i_frame_reader (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_head    (head_desc),
        .i_empty   (desc_empty),
        .i_rd_data (rd_data),
        .o_pop     (desc_pop),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .o_data    (o_data),
        .o_valid   (o_valid),
        .o_last    (o_last),
        .o_user    (o_user),
        .o_len     (o_len)
    );

endmodule

`default_nettype wire

//--- frame_ram.sv
`timescale 1ns/10ps
`default_nettype none

module frame_ram
    import frame_buf_pkg::*;
#(
    parameter int RAM_DEPTH = 2048
) (
    input  wire         i_clk,
    input  wire         i_wr_en,
    input  wire addr_t  i_wr_addr,
    input  wire [7:0]   i_wr_data,
    input  wire         i_rd_en,
    input  wire addr_t  i_rd_addr,
    output logic [7:0]  o_rd_data
);

    // depth has to fit the package address type
    if (RAM_DEPTH < 2 || RAM_DEPTH > (1 << ADDR_W)) begin : g_bad_depth
        $error("frame_ram depth %0d does not fit addr_t", RAM_DEPTH);
    end

    logic [7:0] mem [RAM_DEPTH];

    // write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // registered read, data one cycle after enable
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- frame_reader.sv
`timescale 1ns/10ps
`default_nettype none

module frame_reader
    import frame_buf_pkg::*;
#(
    parameter int RAM_DEPTH = 2048
) (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire frame_desc_t   i_head,
    input  wire                i_empty,
    input  wire [7:0]          i_rd_data,
    output logic               o_pop,
    output logic               o_rd_en,
    output addr_t              o_rd_addr,
    output logic [7:0]         o_data,
    output logic               o_valid,
    output logic               o_last,
    output axis_user_t         o_user,
    output len_t               o_len
);

    if (RAM_DEPTH < 2 || RAM_DEPTH > (1 << ADDR_W)) begin : g_bad_depth
        $error("frame_reader depth %0d does not fit addr_t", RAM_DEPTH);
    end

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_READ = 1'b1;

    logic  state;
    addr_t rd_addr;
    len_t  remaining;
    logic  final_rd;

    //////////////////////////////////////////////////////////////////////
    // descriptor pop and read sequencing
    //////////////////////////////////////////////////////////////////////

    // one pop per frame, only from idle
    assign o_pop     = (state == ST_IDLE) && !i_empty;
    assign o_rd_en   = (state == ST_READ);
    assign o_rd_addr = rd_addr;
    // last ram read of the frame
    assign final_rd  = o_rd_en && (remaining == len_t'(1));

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= ST_IDLE;
            rd_addr   <= '0;
            remaining <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (o_pop) begin
                        state     <= ST_READ;
                        rd_addr   <= i_head.start_addr;
                        remaining <= i_head.length;
                    end
                end
                ST_READ: begin
                    rd_addr   <= addr_next(rd_addr, RAM_DEPTH);
                    remaining <= remaining - len_t'(1);
                    // back to idle leaves a gap before the next frame
                    if (final_rd) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output framing
    //////////////////////////////////////////////////////////////////////

    // valid and last delayed to match the ram read latency
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_valid <= o_rd_en;
            o_last  <= final_rd;
        end
    end

    // sideband taken at the pop, held for the whole frame
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_user <= '0;
            o_len  <= '0;
        end else if (o_pop) begin
            o_user.marker    <= 1'b1;
            o_user.smd       <= i_head.smd;
            o_user.frag      <= i_head.frag;
            o_user.crc_flags <= i_head.crc_flags;
            o_user.rsvd      <= '0;
            o_len            <= i_head.length;
        end
    end

    // stale ram data masked between frames
    assign o_data = o_valid ? i_rd_data : '0;

endmodule

`default_nettype wire

//--- frame_writer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_writer
    import frame_buf_pkg::*;
#(
    parameter int RAM_DEPTH = 2048
) (
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire frame_in_t   i_frame,
    input  wire [7:0]        i_smd,
    input  wire              i_smd_vld,
    input  wire [7:0]        i_frag,
    input  wire              i_frag_vld,
    input  wire              i_desc_full,
    output logic             o_wr_en,
    output addr_t            o_wr_addr,
    output logic [7:0]       o_wr_data,
    output logic             o_desc_push,
    output frame_desc_t      o_desc
);

    if (RAM_DEPTH < 2 || RAM_DEPTH > (1 << ADDR_W)) begin : g_bad_depth
        $error("frame_writer depth %0d does not fit addr_t", RAM_DEPTH);
    end

    logic [7:0]             r_data;
    logic                   r_strb;
    logic                   r_last;
    logic                   r_crc_err;
    logic [7:0]             smd_q;
    logic [FRAG_CODE_W-1:0] frag_q;
    logic [1:0]             crc_flags_q;
    logic                   smd_is_start;
    addr_t                  wr_ptr;
    addr_t                  frame_start;
    addr_t                  cur_start;
    len_t                   byte_cnt;
    logic                   in_frame;
    logic                   keep_frame;

    //////////////////////////////////////////////////////////////////////
    // input stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_strb    <= 1'b0;
            r_last    <= 1'b0;
            r_crc_err <= 1'b0;
        end else begin
            r_strb    <= i_frame.strb;
            r_last    <= i_frame.strb & i_frame.last;
            r_crc_err <= i_frame.crc_err;
        end
    end

    always_ff @(posedge i_clk) begin
        r_data <= i_frame.data;
    end

    // an smd-s start also restarts the fragment count
    assign smd_is_start = i_smd_vld && (i_smd inside {SMD_S0, SMD_S1, SMD_S2, SMD_S3});

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            smd_q       <= '0;
            frag_q      <= '0;
            crc_flags_q <= '0;
        end else begin
            if (i_smd_vld) begin
                smd_q <= i_smd;
            end
            if (smd_is_start) begin
                frag_q <= '0;
            end else if (i_frag_vld) begin
                case (i_frag)
                    SMD_S0:  frag_q <= 2'd0;
                    SMD_S1:  frag_q <= 2'd1;
                    SMD_S2:  frag_q <= 2'd2;
                    SMD_S3:  frag_q <= 2'd3;
                    default: frag_q <= frag_q;
                endcase
            end
            // crc status only meaningful with the final byte
            if (i_frame.strb && i_frame.last) begin
                crc_flags_q <= i_frame.crc_flags;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write addressing
    //////////////////////////////////////////////////////////////////////

    // single byte frame starts at the pointer itself
    assign cur_start  = in_frame ? frame_start : wr_ptr;
    // keep only clean frames that still find a queue slot
    assign keep_frame = r_last && !r_crc_err && !i_desc_full;

    assign o_wr_en     = r_strb;
    assign o_wr_addr   = wr_ptr;
    assign o_wr_data   = r_data;
    assign o_desc_push = keep_frame;

    always_comb begin
        o_desc.smd        = smd_q;
        o_desc.frag       = frag_q;
        o_desc.crc_flags  = crc_flags_q;
        o_desc.start_addr = cur_start;
        o_desc.length     = byte_cnt + len_t'(1);
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr      <= '0;
            frame_start <= '0;
            byte_cnt    <= '0;
            in_frame    <= 1'b0;
        end else if (r_strb) begin
            if (r_last) begin
                in_frame <= 1'b0;
                byte_cnt <= '0;
                // dropped frame gives its space back
                wr_ptr   <= keep_frame ? addr_next(wr_ptr, RAM_DEPTH) : cur_start;
            end else begin
                in_frame <= 1'b1;
                byte_cnt <= byte_cnt + len_t'(1);
                wr_ptr   <= addr_next(wr_ptr, RAM_DEPTH);
                if (!in_frame) begin
                    frame_start <= wr_ptr;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_frame_buf.sv
`timescale 1ns/10ps
`default_nettype none

module tb_frame_buf
    import frame_buf_pkg::*;
();

    localparam int RAM_DEPTH  = 2048;
    localparam int DESC_DEPTH = 16;

    logic       clk;
    logic       rst;
    frame_in_t  rx_frame;
    logic [7:0] rx_smd;
    logic       rx_smd_vld;
    logic [7:0] rx_frag;
    logic       rx_frag_vld;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_last;
    axis_user_t tx_user;
    len_t       tx_len;

    // stimulus and model state
    logic [31:0] rng_state;
    int          err_cnt;
    logic [7:0]  cur_smd;
    logic [1:0]  cur_frag;
    logic [7:0]  sent[$];
    logic [7:0]  exp_data[$];
    axis_user_t  exp_user[$];
    len_t        exp_len[$];
    // monitor state
    logic        mon_in_frame;
    int          mon_idx;
    len_t        mon_len;
    logic [7:0]  mon_byte;
    axis_user_t  mon_user;

    frame_buf_top #(
        .RAM_DEPTH  (RAM_DEPTH),
        .DESC_DEPTH (DESC_DEPTH)
    ) i_frame_buf_top (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_frame    (rx_frame),
        .i_smd      (rx_smd),
        .i_smd_vld  (rx_smd_vld),
        .i_frag     (rx_frag),
        .i_frag_vld (rx_frag_vld),
        .o_data     (tx_data),
        .o_valid    (tx_valid),
        .o_last     (tx_last),
        .o_user     (tx_user),
        .o_len      (tx_len)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // an smd-s code on the smd strobe restarts the fragment count
    task automatic send_smd(input logic [7:0] b);
        @(negedge clk);
        rx_smd     = b;
        rx_smd_vld = 1'b1;
        @(negedge clk);
        rx_smd_vld = 1'b0;
        cur_smd    = b;
        if (b inside {SMD_S0, SMD_S1, SMD_S2, SMD_S3}) begin
            cur_frag = 2'd0;
        end
    endtask

    // unknown fragment count codes leave the count alone
    task automatic send_frag(input logic [7:0] b);
        @(negedge clk);
        rx_frag     = b;
        rx_frag_vld = 1'b1;
        @(negedge clk);
        rx_frag_vld = 1'b0;
        case (b)
            SMD_S0:  cur_frag = 2'd0;
            SMD_S1:  cur_frag = 2'd1;
            SMD_S2:  cur_frag = 2'd2;
            SMD_S3:  cur_frag = 2'd3;
            default: cur_frag = cur_frag;
        endcase
    endtask

    // random payload with crc status on the final byte only
    task automatic send_frame(input int len, input logic err, input logic [1:0] flags);
        logic is_last;
        sent.delete();
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            is_last   = (i == len - 1);
            rng_state = xorshift32(rng_state);
            rx_frame.data      = rng_state[7:0];
            rx_frame.strb      = 1'b1;
            rx_frame.last      = is_last;
            rx_frame.crc_err   = is_last ? err : 1'b0;
            rx_frame.crc_flags = flags;
            sent.push_back(rng_state[7:0]);
        end
        @(negedge clk);
        rx_frame = '0;
    endtask

    // reference model entry for the frame just sent
    task automatic expect_frame(input logic [1:0] flags);
        axis_user_t u;
        u.marker    = 1'b1;
        u.smd       = cur_smd;
        u.frag      = cur_frag;
        u.crc_flags = flags;
        u.rsvd      = 3'b000;
        foreach (sent[i]) begin
            exp_data.push_back(sent[i]);
        end
        exp_user.push_back(u);
        exp_len.push_back(len_t'(sent.size()));
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while ((exp_len.size() != 0 || mon_in_frame) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_len.size() != 0 || mon_in_frame) begin
            $display("timeout waiting for expected frames to come out, %0d errors", err_cnt);
            $display("tests failed");
            $finish;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor
    //////////////////////////////////////////////////////////////////////

    // outputs move on the rising edge and are sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (tx_valid) begin
                if (!mon_in_frame) begin
                    assert (exp_len.size() != 0) else begin
                        err_cnt++;
                        $display("a frame came out that was not expected");
                    end
                    mon_len = '0;
                    if (exp_len.size() != 0) begin
                        mon_len  = exp_len.pop_front();
                        mon_user = exp_user.pop_front();
                        assert (tx_user == mon_user) else begin
                            err_cnt++;
                            $display("FAILED o_user got %h expected %h", tx_user, mon_user);
                        end
                        assert (tx_len == mon_len) else begin
                            err_cnt++;
                            $display("FAILED o_len got %h expected %h", tx_len, mon_len);
                        end
                    end
                    mon_in_frame = 1'b1;
                    mon_idx      = 0;
                end
                if (exp_data.size() != 0) begin
                    mon_byte = exp_data.pop_front();
                    assert (tx_data == mon_byte) else begin
                        err_cnt++;
                        $display("FAILED o_data got %h expected %h", tx_data, mon_byte);
                    end
                end
                assert (tx_last == (mon_idx == int'(mon_len) - 1)) else begin
                    err_cnt++;
                    $display("FAILED o_last got %h expected %h", tx_last,
                             (mon_idx == int'(mon_len) - 1));
                end
                mon_idx++;
                if (tx_last) begin
                    mon_in_frame = 1'b0;
                end
            end else begin
                assert (!mon_in_frame) else begin
                    err_cnt++;
                    $display("o_valid dropped in the middle of a frame");
                end
                assert (!tx_last) else begin
                    err_cnt++;
                    $display("o_last was high without o_valid");
                end
                mon_in_frame = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        assert (!tx_valid) else begin
            err_cnt++;
            $display("FAILED o_valid got %h expected %h", tx_valid, 1'b0);
        end
        assert (!tx_last) else begin
            err_cnt++;
            $display("FAILED o_last got %h expected %h", tx_last, 1'b0);
        end
        assert (tx_user == '0) else begin
            err_cnt++;
            $display("FAILED o_user got %h expected %h", tx_user, 16'h0);
        end
        assert (tx_len == '0) else begin
            err_cnt++;
            $display("FAILED o_len got %h expected %h", tx_len, 12'h0);
        end
    endtask

    task automatic good_frame_intact();
        send_smd(SMD_S0);
        send_frame(64, 1'b0, 2'b11);
        expect_frame(2'b11);
        wait_drain(500);
    endtask

    // bad frame rewinds so the next one lands on the same addresses
    task automatic crc_error_dropped();
        send_frame(64, 1'b1, 2'b00);
        idle_cycles(3);
        send_frame(64, 1'b0, 2'b01);
        expect_frame(2'b01);
        wait_drain(500);
        idle_cycles(20);
    endtask

    task automatic frag_code_sequence();
        logic [7:0] codes[4];
        codes = '{SMD_S0, SMD_S1, SMD_S2, SMD_S3};
        foreach (codes[i]) begin
            send_frag(codes[i]);
            send_frame(16, 1'b0, 2'b10);
            expect_frame(2'b10);
            idle_cycles(3);
        end
        // smd-s strobe brings the count back to 0
        send_smd(SMD_S1);
        send_frame(16, 1'b0, 2'b10);
        expect_frame(2'b10);
        wait_drain(500);
    endtask

    task automatic mixed_burst();
        int lens[8];
        lens = '{1, 17, 60, 128, 3, 250, 40, 99};
        foreach (lens[i]) begin
            send_frame(lens[i], 1'b0, 2'(i));
            expect_frame(2'(i));
            idle_cycles(2);
        end
        wait_drain(2000);
    endtask

    // reader stays on the long frame so nothing leaves the queue
    task automatic queue_overflow();
        int accepted;
        accepted = 0;
        send_frame(600, 1'b0, 2'b11);
        expect_frame(2'b11);
        for (int i = 0; i < DESC_DEPTH + 2; i++) begin
            send_frame(8, 1'b0, 2'b01);
            assert (tx_valid) else begin
                err_cnt++;
                $display("long frame ended before short frame %0d was sent", i);
            end
            // only frames that find a free slot come out
            if (accepted < DESC_DEPTH) begin
                expect_frame(2'b01);
                accepted++;
            end
            idle_cycles(2);
        end
        wait_drain(2000);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rx_frame     = '0;
        rx_smd       = '0;
        rx_smd_vld   = 1'b0;
        rx_frag      = '0;
        rx_frag_vld  = 1'b0;
        rng_state    = 32'd69;
        err_cnt      = 0;
        cur_smd      = '0;
        cur_frag     = '0;
        mon_in_frame = 1'b0;
        mon_idx      = 0;
        mon_len      = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        good_frame_intact();
        crc_error_dropped();
        frag_code_sequence();
        mixed_burst();
        queue_overflow();
        // any late extra frame gets caught by the monitor
        idle_cycles(50);
        $display("run finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
